// ==== src.f ====
+incdir+common
common/csb_pkg.sv
common/csc_reg_pkg.sv
source/csc_csb_port.sv
regfile/csc_dual_reg.sv
regfile/csc_group_ctrl.sv
source/csc_regfile.sv
test/tb_csc_regfile.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_csc_regfile
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard common/*.sv common/*.svh source/*.sv regfile/*.sv test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_csc_regfile.sv ====
`default_nettype none

`include "csc_macros.svh"

module tb_csc_regfile;

  import csb_pkg::*;
  import csc_reg_pkg::*;

  localparam int NUM_OPS        = 400;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 12;

  logic                  nvdla_core_clk;
  logic                  nvdla_core_rstn;
  logic                  csb2csc_req_pvld;
  csb_req_pd_t           csb2csc_req_pd;
  logic                  dp2reg_done;
  logic                  csc2csb_resp_valid;
  csb_resp_pd_t          csc2csb_resp_pd;
  logic                  reg2dp_op_en;
  cube_dim_t             reg2dp_datain_width_ext;
  cube_dim_t             reg2dp_datain_height_ext;
  cube_dim_t             reg2dp_datain_channel_ext;
  cube_dim_t             reg2dp_weight_kernel;

  integer       seed = 91;
  int           cycles;
  int           resp_errors;
  int           field_errors;
  int           bit_errors;
  reg_offset_t  offsets [6];

  // reference model state
  logic         m_cap_vld;
  csb_req_pd_t  m_cap_pd;
  logic         m_prod;
  logic         m_cons;
  logic         m_en [2];
  cube_dim_t    m_width [2];
  cube_dim_t    m_height [2];
  cube_dim_t    m_channel [2];
  cube_dim_t    m_kernel [2];
  logic [2:0]   m_dly;         // enable pipe, msb reaches the datapath
  logic         m_resp_vld;
  csb_resp_pd_t m_resp_pd;

  csc_regfile csc_regfile_inst (
    .nvdla_core_clk            (nvdla_core_clk),
    .nvdla_core_rstn           (nvdla_core_rstn),
    .csb2csc_req_pvld          (csb2csc_req_pvld),
    .csb2csc_req_pd            (csb2csc_req_pd),
    .dp2reg_done               (dp2reg_done),
    .csc2csb_resp_valid        (csc2csb_resp_valid),
    .csc2csb_resp_pd           (csc2csb_resp_pd),
    .reg2dp_op_en              (reg2dp_op_en),
    .reg2dp_datain_width_ext   (reg2dp_datain_width_ext),
    .reg2dp_datain_height_ext  (reg2dp_datain_height_ext),
    .reg2dp_datain_channel_ext (reg2dp_datain_channel_ext),
    .reg2dp_weight_kernel      (reg2dp_weight_kernel)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #10 nvdla_core_clk = ~nvdla_core_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model

  function automatic group_status_e status_of(input logic g);
    if (!m_en[g]) return status_idle;
    return (m_cons == g) ? status_running : status_pending;
  endfunction

  function automatic csb_data_t model_read(input reg_offset_t off);
    csb_data_t d;
    d = '0;
    case (off)
      `CSC_POINTER_OFFSET: begin
        d[0]  = m_prod;
        d[16] = m_cons;
      end
      `CSC_STATUS_OFFSET: begin
        d[1:0]   = status_of(1'b0);
        d[17:16] = status_of(1'b1);
      end
      `CSC_OP_ENABLE_OFFSET:      d[0] = m_en[m_prod];
      `CSC_DATAIN_SIZE_OFFSET: begin
        d[12:0]  = m_width[m_prod];
        d[28:16] = m_height[m_prod];
      end
      `CSC_DATAIN_CHANNEL_OFFSET: d[12:0] = m_channel[m_prod];
      `CSC_WEIGHT_KERNEL_OFFSET:  d[12:0] = m_kernel[m_prod];
      default: ;
    endcase
    return d;
  endfunction

  task automatic reset_model();
    m_cap_vld  = 1'b0;
    m_cap_pd   = '0;
    m_prod     = 1'b0;
    m_cons     = 1'b0;
    m_dly      = '0;
    m_resp_vld = 1'b0;
    m_resp_pd  = '0;
    for (int g = 0; g < 2; g++) begin
      m_en[g]      = 1'b0;
      m_width[g]   = '0;
      m_height[g]  = '0;
      m_channel[g] = '0;
      m_kernel[g]  = '0;
    end
  endtask

  task automatic step_model();
    reg_offset_t off;
    csb_data_t   wd;
    logic        wr;
    logic        rd;
    logic        g;
    logic        wr_ok;
    off   = {m_cap_pd[9:0], 2'b00};
    wd    = m_cap_pd[53:22];
    wr    = m_cap_vld & m_cap_pd[54];
    rd    = m_cap_vld & ~m_cap_pd[54];
    g     = m_prod;
    wr_ok = wr && (off >= `CSC_DUAL_BASE) && !m_en[g];  // running group is frozen
    m_resp_vld = rd | (wr & m_cap_pd[55]);
    if (rd) begin
      m_resp_pd = {2'b00, model_read(off)};
    end else if (wr & m_cap_pd[55]) begin
      m_resp_pd = {2'b10, 32'h0};
    end
    if (dp2reg_done) begin
      m_dly = '0;
    end else begin
      m_dly = {m_dly[1:0], m_en[m_cons]};
    end
    if (dp2reg_done) m_en[m_cons] = 1'b0;
    if (wr_ok) begin
      case (off)
        `CSC_OP_ENABLE_OFFSET:      m_en[g] = wd[0];
        `CSC_DATAIN_SIZE_OFFSET: begin
          m_width[g]  = wd[12:0];
          m_height[g] = wd[28:16];
        end
        `CSC_DATAIN_CHANNEL_OFFSET: m_channel[g] = wd[12:0];
        `CSC_WEIGHT_KERNEL_OFFSET:  m_kernel[g] = wd[12:0];
        default: ;
      endcase
    end
    if (wr && off == `CSC_POINTER_OFFSET) m_prod = wd[0];
    if (dp2reg_done) m_cons = ~m_cons;  // flip last, clear used the old one
    m_cap_vld = csb2csc_req_pvld;
    if (csb2csc_req_pvld) m_cap_pd = csb2csc_req_pd;
  endtask

  always @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      reset_model();
    end else begin
      step_model();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_resp(input string name, input csb_resp_pd_t got, input csb_resp_pd_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      resp_errors++;
    end
  endtask

  task automatic check_field(input string name, input cube_dim_t got, input cube_dim_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      field_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      bit_errors++;
    end
  endtask

  task automatic check_outputs();
    check_bit("csc2csb_resp_valid", csc2csb_resp_valid, m_resp_vld);
    check_resp("csc2csb_resp_pd", csc2csb_resp_pd, m_resp_pd);
    check_bit("reg2dp_op_en", reg2dp_op_en, m_dly[2]);
    check_field("reg2dp_datain_width_ext", reg2dp_datain_width_ext, m_width[m_cons]);
    check_field("reg2dp_datain_height_ext", reg2dp_datain_height_ext, m_height[m_cons]);
    check_field("reg2dp_datain_channel_ext", reg2dp_datain_channel_ext, m_channel[m_cons]);
    check_field("reg2dp_weight_kernel", reg2dp_weight_kernel, m_kernel[m_cons]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  function automatic csb_req_pd_t make_req(input logic write, input logic nposted,
                                           input reg_offset_t off, input csb_data_t data);
    csb_req_pd_t pd;
    pd        = '0;
    pd[21:0]  = {12'h0, off[11:2]};  // word address
    pd[53:22] = data;
    pd[54]    = write;
    pd[55]    = nposted;
    pd[60:57] = 4'hf;
    return pd;
  endfunction

  // falling edge, outputs settled
  task automatic tick();
    @(negedge nvdla_core_clk);
    check_outputs();
  endtask

  task automatic drive(input logic pvld, input csb_req_pd_t pd, input logic done);
    csb2csc_req_pvld = pvld;
    csb2csc_req_pd   = pd;
    dp2reg_done      = done;
  endtask

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge nvdla_core_clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int          kind;
    int          idx;
    int          gap;
    logic        np;
    logic        write;
    csb_data_t   wdata;
    resp_errors      = 0;
    field_errors     = 0;
    bit_errors       = 0;
    nvdla_core_rstn  = 1'b0;
    csb2csc_req_pvld = 1'b0;
    csb2csc_req_pd   = '0;
    dp2reg_done      = 1'b0;
    offsets = '{`CSC_POINTER_OFFSET, `CSC_STATUS_OFFSET, `CSC_OP_ENABLE_OFFSET,
                `CSC_DATAIN_SIZE_OFFSET, `CSC_DATAIN_CHANNEL_OFFSET, `CSC_WEIGHT_KERNEL_OFFSET};
    repeat (3) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;

    for (int i = 0; i < NUM_OPS; i++) begin
      tick();
      kind  = {$random(seed)} % 10;
      idx   = {$random(seed)} % 6;
      wdata = $random(seed);
      np    = (({$random(seed)} % 2) == 1);
      write = (({$random(seed)} % 2) == 1);
      if (kind < 4) begin
        drive(1'b1, make_req(write, np, offsets[idx], wdata), 1'b0);
      end else if (kind < 6) begin
        drive(1'b1, make_req(1'b1, np, `CSC_OP_ENABLE_OFFSET, 32'h1), 1'b0);
      end else if (kind == 6) begin
        drive(1'b1, make_req(1'b1, np, `CSC_POINTER_OFFSET, {31'h0, ~m_prod}), 1'b0);
      end else if (m_dly[2]) begin
        drive(1'b0, '0, 1'b1);  // done only while the datapath runs
      end else begin
        drive(1'b1, make_req(1'b0, np, offsets[idx], wdata), 1'b0);
      end
      gap = {$random(seed)} % 3;
      repeat (gap) begin
        tick();
        drive(1'b0, '0, 1'b0);
      end
    end

    // drain the last responses
    repeat (4) begin
      tick();
      drive(1'b0, '0, 1'b0);
    end

    $display("errors: response %0d, field %0d, control %0d",
             resp_errors, field_errors, bit_errors);
    if (resp_errors + field_errors + bit_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/csc_regfile.sv ====
`default_nettype none

module csc_regfile (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   csb2csc_req_pvld,
  input  csb_pkg::csb_req_pd_t   csb2csc_req_pd,
  input  logic                   dp2reg_done,
  output logic                   csc2csb_resp_valid,
  output csb_pkg::csb_resp_pd_t  csc2csb_resp_pd,
  output logic                   reg2dp_op_en,
  output csc_reg_pkg::cube_dim_t reg2dp_datain_width_ext,
  output csc_reg_pkg::cube_dim_t reg2dp_datain_height_ext,
  output csc_reg_pkg::cube_dim_t reg2dp_datain_channel_ext,
  output csc_reg_pkg::cube_dim_t reg2dp_weight_kernel
);

  import csb_pkg::*;
  import csc_reg_pkg::*;

  logic        reg_wr_en;
  reg_offset_t reg_offset;
  csb_data_t   reg_wr_data;
  csb_data_t   reg_rd_data;
  logic        d0_wr_en;
  logic        d1_wr_en;
  logic        d0_op_en;
  logic        d1_op_en;
  logic        d0_op_en_trigger;
  logic        d1_op_en_trigger;
  csb_data_t   d0_rd_data;
  csb_data_t   d1_rd_data;
  cube_dim_t   d0_datain_width_ext;
  cube_dim_t   d0_datain_height_ext;
  cube_dim_t   d0_datain_channel_ext;
  cube_dim_t   d0_weight_kernel;
  cube_dim_t   d1_datain_width_ext;
  cube_dim_t   d1_datain_height_ext;
  cube_dim_t   d1_datain_channel_ext;
  cube_dim_t   d1_weight_kernel;

  csc_csb_port u_csb_port (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .csb2csc_req_pvld   (csb2csc_req_pvld),
    .csb2csc_req_pd     (csb2csc_req_pd),
    .reg_rd_data        (reg_rd_data),
    .reg_wr_en          (reg_wr_en),
    .reg_offset         (reg_offset),
    .reg_wr_data        (reg_wr_data),
    .csc2csb_resp_valid (csc2csb_resp_valid),
    .csc2csb_resp_pd    (csc2csb_resp_pd)
  );

  // ping-pong pair
  csc_dual_reg u_dual_reg_d0 (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .wr_en              (d0_wr_en),
    .reg_offset         (reg_offset),
    .reg_wr_data        (reg_wr_data),
    .op_en              (d0_op_en),
    .rd_data            (d0_rd_data),
    .op_en_trigger      (d0_op_en_trigger),
    .datain_width_ext   (d0_datain_width_ext),
    .datain_height_ext  (d0_datain_height_ext),
    .datain_channel_ext (d0_datain_channel_ext),
    .weight_kernel      (d0_weight_kernel)
  );

  csc_dual_reg u_dual_reg_d1 (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .wr_en              (d1_wr_en),
    .reg_offset         (reg_offset),
    .reg_wr_data        (reg_wr_data),
    .op_en              (d1_op_en),
    .rd_data            (d1_rd_data),
    .op_en_trigger      (d1_op_en_trigger),
    .datain_width_ext   (d1_datain_width_ext),
    .datain_height_ext  (d1_datain_height_ext),
    .datain_channel_ext (d1_datain_channel_ext),
    .weight_kernel      (d1_weight_kernel)
  );

  csc_group_ctrl u_group_ctrl (
    .nvdla_core_clk            (nvdla_core_clk),
    .nvdla_core_rstn           (nvdla_core_rstn),
    .reg_wr_en                 (reg_wr_en),
    .reg_offset                (reg_offset),
    .reg_wr_data               (reg_wr_data),
    .dp2reg_done               (dp2reg_done),
    .d0_rd_data                (d0_rd_data),
    .d1_rd_data                (d1_rd_data),
    .d0_op_en_trigger          (d0_op_en_trigger),
    .d1_op_en_trigger          (d1_op_en_trigger),
    .d0_datain_width_ext       (d0_datain_width_ext),
    .d0_datain_height_ext      (d0_datain_height_ext),
    .d0_datain_channel_ext     (d0_datain_channel_ext),
    .d0_weight_kernel          (d0_weight_kernel),
    .d1_datain_width_ext       (d1_datain_width_ext),
    .d1_datain_height_ext      (d1_datain_height_ext),
    .d1_datain_channel_ext     (d1_datain_channel_ext),
    .d1_weight_kernel          (d1_weight_kernel),
    .reg_rd_data               (reg_rd_data),
    .d0_wr_en                  (d0_wr_en),
    .d1_wr_en                  (d1_wr_en),
    .d0_op_en                  (d0_op_en),
    .d1_op_en                  (d1_op_en),
    .reg2dp_op_en              (reg2dp_op_en),
    .reg2dp_datain_width_ext   (reg2dp_datain_width_ext),
    .reg2dp_datain_height_ext  (reg2dp_datain_height_ext),
    .reg2dp_datain_channel_ext (reg2dp_datain_channel_ext),
    .reg2dp_weight_kernel      (reg2dp_weight_kernel)
  );

endmodule

`default_nettype wire

// ==== regfile/csc_group_ctrl.sv ====
`default_nettype none

`include "csc_macros.svh"

module csc_group_ctrl (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   reg_wr_en,
  input  csb_pkg::reg_offset_t   reg_offset,
  input  csb_pkg::csb_data_t     reg_wr_data,
  input  logic                   dp2reg_done,
  input  csb_pkg::csb_data_t     d0_rd_data,
  input  csb_pkg::csb_data_t     d1_rd_data,
  input  logic                   d0_op_en_trigger,
  input  logic                   d1_op_en_trigger,
  input  csc_reg_pkg::cube_dim_t d0_datain_width_ext,
  input  csc_reg_pkg::cube_dim_t d0_datain_height_ext,
  input  csc_reg_pkg::cube_dim_t d0_datain_channel_ext,
  input  csc_reg_pkg::cube_dim_t d0_weight_kernel,
  input  csc_reg_pkg::cube_dim_t d1_datain_width_ext,
  input  csc_reg_pkg::cube_dim_t d1_datain_height_ext,
  input  csc_reg_pkg::cube_dim_t d1_datain_channel_ext,
  input  csc_reg_pkg::cube_dim_t d1_weight_kernel,
  output csb_pkg::csb_data_t     reg_rd_data,
  output logic                   d0_wr_en,
  output logic                   d1_wr_en,
  output logic                   d0_op_en,
  output logic                   d1_op_en,
  output logic                   reg2dp_op_en,
  output csc_reg_pkg::cube_dim_t reg2dp_datain_width_ext,
  output csc_reg_pkg::cube_dim_t reg2dp_datain_height_ext,
  output csc_reg_pkg::cube_dim_t reg2dp_datain_channel_ext,
  output csc_reg_pkg::cube_dim_t reg2dp_weight_kernel
);

  import csb_pkg::*;
  import csc_reg_pkg::*;

  logic          producer;
  logic          consumer;
  logic          select_s;
  group_status_e status_0;
  group_status_e status_1;
  csb_data_t     s_rd_data;
  logic          op_en_ori;
  logic [`CSC_OP_EN_DELAY-1:0] op_en_dly;

  ////////////////////////////////////////////////////////////////////////////
  // single group and write steering

  assign select_s = (reg_offset < `CSC_DUAL_BASE);
  assign d0_wr_en = reg_wr_en & ~select_s & ~producer & ~d0_op_en;
  assign d1_wr_en = reg_wr_en & ~select_s & producer & ~d1_op_en;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
      consumer <= 1'b0;
    end else begin
      if (reg_wr_en && reg_offset == `CSC_POINTER_OFFSET) begin
        producer <= reg_wr_data[`CSC_PRODUCER_BIT];
      end
      if (dp2reg_done) begin
        consumer <= ~consumer;  // hand over to the other group
      end
    end
  end

  assign status_0 = !d0_op_en ? status_idle : consumer ? status_pending : status_running;
  assign status_1 = !d1_op_en ? status_idle : consumer ? status_running : status_pending;

  always_comb begin
    s_rd_data = '0;
    case (reg_offset)
      `CSC_POINTER_OFFSET: begin
        s_rd_data[`CSC_PRODUCER_BIT] = producer;
        s_rd_data[`CSC_CONSUMER_BIT] = consumer;
      end
      `CSC_STATUS_OFFSET: begin
        s_rd_data[`CSC_STATUS_0_LSB +: 2] = status_0;
        s_rd_data[`CSC_STATUS_1_LSB +: 2] = status_1;
      end
      default: ;
    endcase
  end

  // producer's group answers above the single group
  assign reg_rd_data = select_s ? s_rd_data : (producer ? d1_rd_data : d0_rd_data);

  ////////////////////////////////////////////////////////////////////////////
  // group enables and delay toward the datapath

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      d0_op_en <= 1'b0;
      d1_op_en <= 1'b0;
    end else begin
      if (~d0_op_en & d0_op_en_trigger) begin
        d0_op_en <= reg_wr_data[`CSC_OP_EN_BIT];
      end else if (dp2reg_done && !consumer) begin
        d0_op_en <= 1'b0;
      end
      if (~d1_op_en & d1_op_en_trigger) begin
        d1_op_en <= reg_wr_data[`CSC_OP_EN_BIT];
      end else if (dp2reg_done && consumer) begin
        d1_op_en <= 1'b0;
      end
    end
  end

  assign op_en_ori = consumer ? d1_op_en : d0_op_en;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_dly <= '0;
    end else if (dp2reg_done) begin
      op_en_dly <= '0;  // drop op_en right after completion
    end else begin
      op_en_dly <= {op_en_dly[`CSC_OP_EN_DELAY-2:0], op_en_ori};
    end
  end

  assign reg2dp_op_en = op_en_dly[`CSC_OP_EN_DELAY-1];

  // datapath sees the consumer's group
  assign reg2dp_datain_width_ext   = consumer ? d1_datain_width_ext : d0_datain_width_ext;
  assign reg2dp_datain_height_ext  = consumer ? d1_datain_height_ext : d0_datain_height_ext;
  assign reg2dp_datain_channel_ext = consumer ? d1_datain_channel_ext : d0_datain_channel_ext;
  assign reg2dp_weight_kernel      = consumer ? d1_weight_kernel : d0_weight_kernel;

  // datapath only runs on a group that software sees as running
  a_running_on_op_en: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    reg2dp_op_en |-> ((consumer ? status_1 : status_0) == status_running)
  );

  a_consumer_on_done: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    $changed(consumer) |-> $past(dp2reg_done)
  );

endmodule

`default_nettype wire

// ==== regfile/csc_dual_reg.sv ====
`default_nettype none

`include "csc_macros.svh"

module csc_dual_reg (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   wr_en,
  input  csb_pkg::reg_offset_t   reg_offset,
  input  csb_pkg::csb_data_t     reg_wr_data,
  input  logic                   op_en,
  output csb_pkg::csb_data_t     rd_data,
  output logic                   op_en_trigger,
  output csc_reg_pkg::cube_dim_t datain_width_ext,
  output csc_reg_pkg::cube_dim_t datain_height_ext,
  output csc_reg_pkg::cube_dim_t datain_channel_ext,
  output csc_reg_pkg::cube_dim_t weight_kernel
);

  import csb_pkg::*;
  import csc_reg_pkg::*;

  // enable itself lives in the group controller
  assign op_en_trigger = wr_en & (reg_offset == `CSC_OP_ENABLE_OFFSET);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      datain_width_ext   <= '0;
      datain_height_ext  <= '0;
      datain_channel_ext <= '0;
      weight_kernel      <= '0;
    end else if (wr_en) begin
      case (reg_offset)
        `CSC_DATAIN_SIZE_OFFSET: begin
          datain_width_ext  <= reg_wr_data[`CSC_WIDTH_LSB +: $bits(cube_dim_t)];
          datain_height_ext <= reg_wr_data[`CSC_HEIGHT_LSB +: $bits(cube_dim_t)];
        end
        `CSC_DATAIN_CHANNEL_OFFSET: begin
          datain_channel_ext <= reg_wr_data[`CSC_CHANNEL_LSB +: $bits(cube_dim_t)];
        end
        `CSC_WEIGHT_KERNEL_OFFSET: begin
          weight_kernel <= reg_wr_data[`CSC_KERNEL_LSB +: $bits(cube_dim_t)];
        end
        default: ;
      endcase
    end
  end

  // readback
  always_comb begin
    rd_data = '0;
    case (reg_offset)
      `CSC_OP_ENABLE_OFFSET:   rd_data[`CSC_OP_EN_BIT] = op_en;
      `CSC_DATAIN_SIZE_OFFSET: begin
        rd_data[`CSC_WIDTH_LSB +: $bits(cube_dim_t)]  = datain_width_ext;
        rd_data[`CSC_HEIGHT_LSB +: $bits(cube_dim_t)] = datain_height_ext;
      end
      `CSC_DATAIN_CHANNEL_OFFSET: rd_data[`CSC_CHANNEL_LSB +: $bits(cube_dim_t)] = datain_channel_ext;
      `CSC_WEIGHT_KERNEL_OFFSET:  rd_data[`CSC_KERNEL_LSB +: $bits(cube_dim_t)] = weight_kernel;
      default: ;
    endcase
  end

  // a running group must stay frozen
  a_no_write_while_enabled: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !(wr_en && op_en)
  );

endmodule

`default_nettype wire

// ==== source/csc_csb_port.sv ====
`default_nettype none

module csc_csb_port (
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  input  logic                  csb2csc_req_pvld,
  input  csb_pkg::csb_req_pd_t  csb2csc_req_pd,
  input  csb_pkg::csb_data_t    reg_rd_data,
  output logic                  reg_wr_en,
  output csb_pkg::reg_offset_t  reg_offset,
  output csb_pkg::csb_data_t    reg_wr_data,
  output logic                  csc2csb_resp_valid,
  output csb_pkg::csb_resp_pd_t csc2csb_resp_pd
);

  import csb_pkg::*;

  logic         req_pvld;
  csb_req_pd_t  req_pd;
  csb_addr_t    req_addr;
  csb_data_t    req_wdat;
  logic         req_write;
  logic         req_nposted;
  logic         reg_rd_en;
  csb_resp_pd_t rresp_pd;
  csb_resp_pd_t wresp_pd;

  ////////////////////////////////////////////////////////////////////////////
  // request capture

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_pvld <= 1'b0;
    end else begin
      req_pvld <= csb2csc_req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (csb2csc_req_pvld) begin
      req_pd <= csb2csc_req_pd;  // held until the next request
    end
  end

  // unpack
  assign req_addr    = req_pd[21:0];
  assign req_wdat    = req_pd[53:22];
  assign req_write   = req_pd[54];
  assign req_nposted = req_pd[55];

  // bus address is word based, the register map is byte based
  assign reg_offset  = {req_addr[9:0], 2'b00};
  assign reg_wr_data = req_wdat;
  assign reg_wr_en   = req_pvld & req_write;
  assign reg_rd_en   = req_pvld & ~req_write;

  ////////////////////////////////////////////////////////////////////////////
  // response

  assign rresp_pd = {1'b0, 1'b0, reg_rd_data};  // read reply, no error
  assign wresp_pd = {1'b1, 1'b0, 32'h0};        // write reply carries no data

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      csc2csb_resp_valid <= 1'b0;
      csc2csb_resp_pd    <= '0;
    end else begin
      csc2csb_resp_valid <= reg_rd_en | (reg_wr_en & req_nposted);
      if (reg_rd_en) begin
        csc2csb_resp_pd <= rresp_pd;
      end else if (reg_wr_en & req_nposted) begin
        csc2csb_resp_pd <= wresp_pd;
      end
    end
  end

endmodule

`default_nettype wire

// ==== common/csc_reg_pkg.sv ====
`default_nettype none

package csc_reg_pkg;

  // stored size minus one
  typedef logic [12:0] cube_dim_t;

  // per-group status as seen by software
  typedef enum logic [1:0] {
    status_idle    = 2'd0,  // enable clear
    status_running = 2'd1,  // enabled, consumer points here
    status_pending = 2'd2   // enabled, waiting for the other group
  } group_status_e;

endpackage

`default_nettype wire

// ==== common/csb_pkg.sv ====
`default_nettype none

package csb_pkg;

  // request packet from the register bus master
  //   [21:0]  word address
  //   [53:22] write data
  //   [54]    write
  //   [55]    non-posted
  //   [56]    source privilege
  //   [60:57] byte enables
  //   [62:61] level
  typedef logic [62:0] csb_req_pd_t;

  // response packet, [31:0] data, [32] error, [33] 0 read / 1 write
  typedef logic [33:0] csb_resp_pd_t;

  typedef logic [21:0] csb_addr_t;    // word address
  typedef logic [31:0] csb_data_t;
  typedef logic [11:0] reg_offset_t;  // byte offset in the 4KB unit space

endpackage

`default_nettype wire

// ==== common/csc_macros.svh ====
`ifndef CSC_MACROS_SVH
`define CSC_MACROS_SVH

// single group offsets
`define CSC_POINTER_OFFSET        12'h000
`define CSC_STATUS_OFFSET         12'h004

// producer's duplicated group starts here
`define CSC_DUAL_BASE             12'h008
`define CSC_OP_ENABLE_OFFSET      12'h008
`define CSC_DATAIN_SIZE_OFFSET    12'h00c
`define CSC_DATAIN_CHANNEL_OFFSET 12'h010
`define CSC_WEIGHT_KERNEL_OFFSET  12'h014

// field positions inside a register word
`define CSC_PRODUCER_BIT          0
`define CSC_CONSUMER_BIT          16
`define CSC_STATUS_0_LSB          0
`define CSC_STATUS_1_LSB          16
`define CSC_OP_EN_BIT             0
`define CSC_WIDTH_LSB             0
`define CSC_HEIGHT_LSB            16
`define CSC_CHANNEL_LSB           0
`define CSC_KERNEL_LSB            0

`define CSC_OP_EN_DELAY           3  // op_en stages toward the datapath

`endif
